// File: Makefile
SIM = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP = core_tb
FILELIST = rv_pipeline.f
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(BUILD_DIR)

// File: rv_pipeline.f
source/core_pkg.sv
source/alu.sv
source/register_file.sv
source/control_unit.sv
source/forwarding_unit.sv
source/hazard_unit.sv
source/dataflow.sv
source/core_top.sv
tb/core_assertions.sv
tb/core_tb.sv

// File: source/alu.sv
`timescale 1ns/10ps

module alu import core_pkg::*; (
  input data_t a,
  input data_t b,
  input alu_op_t op,
  output data_t y
);

  always_comb begin
    case (op)
      AluAdd: y = a + b;
      AluSub: y = a - b;
      AluAnd: y = a & b;
      AluOr: y = a | b;
      AluXor: y = a ^ b;
      AluSlt: y = {31'b0, $signed(a) < $signed(b)};
      AluSll: y = a << b[4:0];
      AluSrl: y = a >> b[4:0];
      // LUI immediate goes through untouched
      AluPassB: y = b;
      default: y = '0;
    endcase
  end

endmodule

// File: source/control_unit.sv
`timescale 1ns/10ps

module control_unit import core_pkg::*; (
  input opcode_t opcode,
  input logic [2:0] funct3,
  input logic [6:0] funct7,
  output alu_op_t alu_op,
  output logic alub_src,
  output logic mem_rd_en,
  output logic mem_wr_en,
  output wr_src_t wr_src,
  output logic reg_we,
  output logic branch,
  output logic jump
);

  alu_op_t arith_op;
  logic arith_ok;

  // Shared funct3 decode of register and immediate forms
  always_comb begin
    arith_ok = 1'b1;
    case (funct3)
      3'b000: arith_op = (opcode == OpReg && funct7[5]) ? AluSub : AluAdd;
      3'b001: arith_op = AluSll;
      3'b010: arith_op = AluSlt;
      3'b100: arith_op = AluXor;
      3'b101: arith_op = AluSrl;
      3'b110: arith_op = AluOr;
      3'b111: arith_op = AluAnd;
      default: begin
        arith_op = AluAdd;
        arith_ok = 1'b0;
      end
    endcase
    // Only SUB may set funct7 in R-type
    if (opcode == OpReg && funct7 != 7'b0 && !(funct7 == 7'b0100000 && funct3 == 3'b000)) begin
      arith_ok = 1'b0;
    end
    // SRAI and shifts with junk in imm[11:5]
    if (opcode == OpImm && funct3[1:0] == 2'b01 && funct7 != 7'b0) begin
      arith_ok = 1'b0;
    end
  end

  always_comb begin
    alu_op = AluAdd;
    alub_src = 1'b0;
    mem_rd_en = 1'b0;
    mem_wr_en = 1'b0;
    wr_src = WrAluY;
    reg_we = 1'b0;
    branch = 1'b0;
    jump = 1'b0;
    case (opcode)
      OpReg: begin
        alu_op = arith_op;
        reg_we = arith_ok;
      end
      OpImm: begin
        alu_op = arith_op;
        alub_src = 1'b1;
        reg_we = arith_ok;
      end
      OpLui: begin
        alu_op = AluPassB;
        alub_src = 1'b1;
        reg_we = 1'b1;
      end
      OpLoad: begin
        alub_src = 1'b1;
        mem_rd_en = (funct3 == 3'b010);
        wr_src = WrReadData;
        reg_we = (funct3 == 3'b010);
      end
      OpStore: begin
        alub_src = 1'b1;
        mem_wr_en = (funct3 == 3'b010);
      end
      // BEQ and BNE only
      OpBranch: branch = (funct3[2:1] == 2'b00);
      OpJal: begin
        jump = 1'b1;
        wr_src = WrPcPlus4;
        reg_we = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// File: source/core_pkg.sv
package core_pkg;

  typedef logic [31:0] data_t;
  typedef logic [4:0] reg_addr_t;
  typedef logic [31:0] inst_t;

  // RV32I major opcodes in use
  typedef enum logic [6:0] {
    OpReg    = 7'b0110011,
    OpImm    = 7'b0010011,
    OpLui    = 7'b0110111,
    OpLoad   = 7'b0000011,
    OpStore  = 7'b0100011,
    OpBranch = 7'b1100011,
    OpJal    = 7'b1101111
  } opcode_t;

  typedef enum logic [3:0] {
    AluAdd,
    AluSub,
    AluAnd,
    AluOr,
    AluXor,
    AluSlt,
    AluSll,
    AluSrl,
    AluPassB
  } alu_op_t;

  typedef enum logic [1:0] {
    NoForwarding,
    ForwardFromMem,
    ForwardFromWb
  } fwd_sel_t;

  typedef enum logic [1:0] {
    WrAluY,
    WrReadData,
    WrPcPlus4
  } wr_src_t;

  // addi x0, x0, 0
  localparam inst_t nop_inst = 32'h0000_0013;

endpackage

// File: source/core_top.sv
`timescale 1ns/10ps

module core_top import core_pkg::*; (
  input logic clock,
  input logic reset,
  input inst_t inst,
  output data_t inst_mem_addr,
  input data_t rd_data,
  output logic rd_en,
  output logic wr_en,
  output data_t data_mem_addr,
  output data_t wr_data,
  input logic mem_busy
);

  // Decode
  opcode_t opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  alu_op_t alu_op;
  logic alub_src, mem_rd_en, mem_wr_en, reg_we, branch, jump;
  wr_src_t wr_src;

  // Register reports and forward selects
  reg_addr_t rs1_id, rs2_id, rs1_ex, rs2_ex, rs2_mem, rd_ex, rd_mem, rd_wb;
  logic reg_we_ex, reg_we_mem, reg_we_wb;
  wr_src_t wr_src_mem;
  fwd_sel_t fwd_rs1_id, fwd_rs2_id, fwd_rs1_ex, fwd_rs2_ex, fwd_rs2_mem;

  // Hazards
  logic load_ex, load_mem, uses_rs2_id, branch_taken, stall, flush_id;

  dataflow u_dataflow (.*);

  control_unit u_control_unit (.*);

  forwarding_unit u_forwarding_unit (.*);

  hazard_unit u_hazard_unit (
    .*,
    .branch_id(branch)
  );

endmodule

// File: source/dataflow.sv
`timescale 1ns/10ps

module dataflow import core_pkg::*; (
  input logic clock,
  input logic reset,
  input inst_t inst,
  output data_t inst_mem_addr,
  input data_t rd_data,
  output logic rd_en,
  output logic wr_en,
  output data_t data_mem_addr,
  output data_t wr_data,
  input logic mem_busy,
  input alu_op_t alu_op,
  input logic alub_src,
  input logic mem_rd_en,
  input logic mem_wr_en,
  input wr_src_t wr_src,
  input logic reg_we,
  input logic branch,
  input logic jump,
  output opcode_t opcode,
  output logic [2:0] funct3,
  output logic [6:0] funct7,
  input fwd_sel_t fwd_rs1_id,
  input fwd_sel_t fwd_rs2_id,
  input fwd_sel_t fwd_rs1_ex,
  input fwd_sel_t fwd_rs2_ex,
  input fwd_sel_t fwd_rs2_mem,
  output reg_addr_t rs1_id,
  output reg_addr_t rs2_id,
  output reg_addr_t rs1_ex,
  output reg_addr_t rs2_ex,
  output reg_addr_t rs2_mem,
  output reg_addr_t rd_ex,
  output reg_addr_t rd_mem,
  output reg_addr_t rd_wb,
  output logic reg_we_ex,
  output logic reg_we_mem,
  output logic reg_we_wb,
  output wr_src_t wr_src_mem,
  output logic load_ex,
  output logic load_mem,
  output logic uses_rs2_id,
  input logic stall,
  input logic flush_id,
  output logic branch_taken
);

  data_t pc, pc_id, pc_plus_4_id, target_id;
  inst_t inst_id;
  data_t rf_data1, rf_data2, rs1_val_id, rs2_val_id;
  data_t imm_i, imm_s, imm_b, imm_u, imm_j, imm_id;
  data_t pc_plus_4_ex, a_ex, b_ex, imm_ex, op_a, rs2_val_ex, alu_y;
  alu_op_t alu_op_ex;
  logic alub_src_ex, store_ex;
  wr_src_t wr_src_ex;
  data_t pc_plus_4_mem, alu_y_mem, store_data_mem, mem_result;
  logic store_mem;
  data_t pc_plus_4_wb, alu_y_wb, read_data_wb, wb_data;
  wr_src_t wr_src_wb;

  function automatic data_t fwd_pick(fwd_sel_t sel, data_t base, data_t from_mem,
                                     data_t from_wb);
    case (sel)
      ForwardFromMem: return from_mem;
      ForwardFromWb: return from_wb;
      default: return base;
    endcase
  endfunction

  // IF
  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= '0;
    end else if (!mem_busy && !stall) begin
      pc <= flush_id ? target_id : pc + 32'd4;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      inst_id <= nop_inst;
    end else if (!mem_busy) begin
      if (flush_id) begin
        inst_id <= nop_inst;
      end else if (!stall) begin
        inst_id <= inst;
        pc_id <= pc;
      end
    end
  end

  // ID
  assign opcode = opcode_t'(inst_id[6:0]);
  assign funct3 = inst_id[14:12];
  assign funct7 = inst_id[31:25];
  // LUI and JAL carry immediate bits in the rs1 field
  assign rs1_id = (opcode == OpLui || opcode == OpJal) ? '0 : inst_id[19:15];
  assign rs2_id = inst_id[24:20];
  assign uses_rs2_id = (opcode == OpReg || opcode == OpStore || opcode == OpBranch);

  register_file u_register_file (
    .clock(clock),
    .reset(reset),
    .rd_addr1(rs1_id),
    .rd_addr2(rs2_id),
    .rd_data1(rf_data1),
    .rd_data2(rf_data2),
    .wr_en(reg_we_wb && !mem_busy),
    .wr_addr(rd_wb),
    .wr_data(wb_data)
  );

  assign imm_i = {{20{inst_id[31]}}, inst_id[31:20]};
  assign imm_s = {{20{inst_id[31]}}, inst_id[31:25], inst_id[11:7]};
  assign imm_b = {{19{inst_id[31]}}, inst_id[31], inst_id[7], inst_id[30:25], inst_id[11:8], 1'b0};
  assign imm_u = {inst_id[31:12], 12'b0};
  assign imm_j = {{11{inst_id[31]}}, inst_id[31], inst_id[19:12], inst_id[20],
                  inst_id[30:21], 1'b0};
  assign imm_id = (opcode == OpStore) ? imm_s : (opcode == OpLui) ? imm_u : imm_i;

  assign rs1_val_id = fwd_pick(fwd_rs1_id, rf_data1, mem_result, wb_data);
  assign rs2_val_id = fwd_pick(fwd_rs2_id, rf_data2, mem_result, wb_data);

  // funct3[0] turns BEQ into BNE
  assign branch_taken = jump || (branch && ((rs1_val_id == rs2_val_id) ^ funct3[0]));
  assign target_id = pc_id + (jump ? imm_j : imm_b);
  assign pc_plus_4_id = pc_id + 32'd4;

  always_ff @(posedge clock) begin
    if (reset || (!mem_busy && stall)) begin
      reg_we_ex <= 1'b0;
      load_ex <= 1'b0;
      store_ex <= 1'b0;
      rd_ex <= '0;
      rs1_ex <= '0;
      rs2_ex <= '0;
    end else if (!mem_busy) begin
      reg_we_ex <= reg_we;
      load_ex <= mem_rd_en;
      store_ex <= mem_wr_en;
      rd_ex <= inst_id[11:7];
      rs1_ex <= rs1_id;
      rs2_ex <= rs2_id;
      pc_plus_4_ex <= pc_plus_4_id;
      a_ex <= rs1_val_id;
      b_ex <= rs2_val_id;
      imm_ex <= imm_id;
      alu_op_ex <= alu_op;
      alub_src_ex <= alub_src;
      wr_src_ex <= wr_src;
    end
  end

  // EX
  assign op_a = fwd_pick(fwd_rs1_ex, a_ex, mem_result, wb_data);
  assign rs2_val_ex = fwd_pick(fwd_rs2_ex, b_ex, mem_result, wb_data);

  alu u_alu (
    .a(op_a),
    .b(alub_src_ex ? imm_ex : rs2_val_ex),
    .op(alu_op_ex),
    .y(alu_y)
  );

  always_ff @(posedge clock) begin
    if (reset) begin
      reg_we_mem <= 1'b0;
      load_mem <= 1'b0;
      store_mem <= 1'b0;
      rd_mem <= '0;
      rs2_mem <= '0;
      wr_src_mem <= WrAluY;
    end else if (!mem_busy) begin
      reg_we_mem <= reg_we_ex;
      load_mem <= load_ex;
      store_mem <= store_ex;
      rd_mem <= rd_ex;
      rs2_mem <= rs2_ex;
      wr_src_mem <= wr_src_ex;
      pc_plus_4_mem <= pc_plus_4_ex;
      alu_y_mem <= alu_y;
      store_data_mem <= rs2_val_ex;
    end
  end

  // MEM
  assign mem_result = (wr_src_mem == WrPcPlus4) ? pc_plus_4_mem : alu_y_mem;

  always_ff @(posedge clock) begin
    if (reset) begin
      reg_we_wb <= 1'b0;
      rd_wb <= '0;
      wr_src_wb <= WrAluY;
    end else if (!mem_busy) begin
      reg_we_wb <= reg_we_mem;
      rd_wb <= rd_mem;
      wr_src_wb <= wr_src_mem;
      pc_plus_4_wb <= pc_plus_4_mem;
      alu_y_wb <= alu_y_mem;
      read_data_wb <= rd_data;
    end
  end

  // WB
  always_comb begin
    case (wr_src_wb)
      WrReadData: wb_data = read_data_wb;
      WrPcPlus4: wb_data = pc_plus_4_wb;
      default: wb_data = alu_y_wb;
    endcase
  end

  assign inst_mem_addr = pc;
  assign rd_en = load_mem;
  assign wr_en = store_mem;
  assign data_mem_addr = alu_y_mem;
  assign wr_data = (fwd_rs2_mem == ForwardFromWb) ? wb_data : store_data_mem;

endmodule

// File: source/forwarding_unit.sv
`timescale 1ns/10ps

module forwarding_unit import core_pkg::*; (
  input reg_addr_t rs1_id,
  input reg_addr_t rs2_id,
  input reg_addr_t rs1_ex,
  input reg_addr_t rs2_ex,
  input reg_addr_t rs2_mem,
  input reg_addr_t rd_mem,
  input reg_addr_t rd_wb,
  input logic reg_we_mem,
  input logic reg_we_wb,
  input wr_src_t wr_src_mem,
  output fwd_sel_t fwd_rs1_id,
  output fwd_sel_t fwd_rs2_id,
  output fwd_sel_t fwd_rs1_ex,
  output fwd_sel_t fwd_rs2_ex,
  output fwd_sel_t fwd_rs2_mem
);

  // Youngest producer wins; loads in MEM have no data yet
  function automatic fwd_sel_t pick(reg_addr_t rs, logic allow_mem);
    fwd_sel_t sel;
    sel = NoForwarding;
    if (rs != '0) begin
      if (allow_mem && reg_we_mem && rd_mem == rs && wr_src_mem != WrReadData) begin
        sel = ForwardFromMem;
      end else if (reg_we_wb && rd_wb == rs) begin
        sel = ForwardFromWb;
      end
    end
    return sel;
  endfunction

  always_comb begin
    fwd_rs1_id = pick(rs1_id, 1'b1);
    fwd_rs2_id = pick(rs2_id, 1'b1);
    fwd_rs1_ex = pick(rs1_ex, 1'b1);
    fwd_rs2_ex = pick(rs2_ex, 1'b1);
    // Store data in MEM can only come from WB
    fwd_rs2_mem = pick(rs2_mem, 1'b0);
  end

endmodule

// File: source/hazard_unit.sv
`timescale 1ns/10ps

module hazard_unit import core_pkg::*; (
  input reg_addr_t rs1_id,
  input reg_addr_t rs2_id,
  input logic uses_rs2_id,
  input logic branch_id,
  input reg_addr_t rd_ex,
  input logic reg_we_ex,
  input logic load_ex,
  input reg_addr_t rd_mem,
  input logic load_mem,
  input logic branch_taken,
  output logic stall,
  output logic flush_id
);

  logic hit_ex;
  logic hit_mem;

  // ID sources against the destination one and two stages ahead
  assign hit_ex = reg_we_ex && rd_ex != '0 &&
                  (rd_ex == rs1_id || (uses_rs2_id && rd_ex == rs2_id));
  assign hit_mem = load_mem && rd_mem != '0 &&
                   (rd_mem == rs1_id || (uses_rs2_id && rd_mem == rs2_id));

  assign stall = (load_ex && hit_ex) || (branch_id && (hit_ex || hit_mem));
  assign flush_id = branch_taken && !stall;

endmodule

// File: source/register_file.sv
`timescale 1ns/10ps

module register_file import core_pkg::*; (
  input logic clock,
  input logic reset,
  input reg_addr_t rd_addr1,
  input reg_addr_t rd_addr2,
  output data_t rd_data1,
  output data_t rd_data2,
  input logic wr_en,
  input reg_addr_t wr_addr,
  input data_t wr_data
);

  data_t regs [1:31];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // x0 reads zero, a same-cycle write passes straight through
  function automatic data_t read_port(reg_addr_t addr);
    if (addr == '0) return '0;
    if (wr_en && wr_addr == addr) return wr_data;
    return regs[addr];
  endfunction

  always_comb begin
    rd_data1 = read_port(rd_addr1);
    rd_data2 = read_port(rd_addr2);
  end

endmodule

// File: tb/core_assertions.sv
`timescale 1ns/10ps

module core_assertions import core_pkg::*; (
  input logic clock,
  input logic reset,
  input logic mem_busy,
  input logic rd_en,
  input logic wr_en,
  input data_t data_mem_addr,
  input data_t wr_data,
  input logic stall,
  input logic flush_id
);

  // One memory access per instruction
  mem_access_exclusive: assert property (
    @(posedge clock) disable iff (reset) !(rd_en && wr_en)
  ) else $error("rd_en and wr_en are high in the same cycle");

  flush_without_stall: assert property (
    @(posedge clock) disable iff (reset) !(flush_id && stall)
  ) else $error("flush_id and stall are high in the same cycle");

  // Memory port frozen while busy
  enables_hold_while_busy: assert property (
    @(posedge clock) disable iff (reset)
      mem_busy |=> $stable(rd_en) && $stable(wr_en)
  ) else $error("memory enables changed while mem_busy was high");

  access_holds_while_busy: assert property (
    @(posedge clock) disable iff (reset)
      mem_busy && (rd_en || wr_en) |=> $stable(data_mem_addr) && $stable(wr_data)
  ) else $error("memory address or write data changed while mem_busy was high");

endmodule

bind dataflow core_assertions u_core_assertions (
  .clock(clock),
  .reset(reset),
  .mem_busy(mem_busy),
  .rd_en(rd_en),
  .wr_en(wr_en),
  .data_mem_addr(data_mem_addr),
  .wr_data(wr_data),
  .stall(stall),
  .flush_id(flush_id)
);

// File: tb/core_tb.sv
`timescale 1ns/10ps

module core_tb import core_pkg::*; ();

  typedef enum int {
    KAdd, KSub, KAnd, KOr, KXor, KSlt, KSll, KSrl,
    KAddi, KAndi, KOri, KXori, KSlti, KSlli, KSrli,
    KLui, KLw, KSw, KBeq, KBne, KJal
  } kind_t;

  localparam int n_random = 200;
  localparam int loop_index = n_random + 7;
  localparam int max_cycles = 20000;
  localparam int drain_cycles = 40;
  localparam int max_model_steps = 10000;

  logic clock;
  logic reset;
  inst_t inst;
  data_t inst_mem_addr;
  data_t rd_data;
  logic rd_en;
  logic wr_en;
  data_t data_mem_addr;
  data_t wr_data;
  logic mem_busy;

  // Program held as fields and as encoded words
  inst_t prog [0:255];
  kind_t kind [0:255];
  reg_addr_t rd_f [0:255];
  reg_addr_t rs1_f [0:255];
  reg_addr_t rs2_f [0:255];
  data_t imm_f [0:255];
  data_t dmem [0:63];
  data_t exp_addr [$];
  data_t exp_data [$];
  int busy_left;
  int seen_stores;
  int cycles;
  bit verdict_printed;

  core_top dut (.*);

  always #2 clock = ~clock;

  task automatic stop_with_failure(string why);
    $display("%s", why);
    $display("Testbench failed");
    verdict_printed = 1'b1;
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check(string name, data_t expected, data_t actual);
    if (expected !== actual) begin
      stop_with_failure($sformatf("ERR %s expected %h actual %h", name, expected, actual));
    end
  endtask

  function automatic inst_t encode(kind_t k, reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2,
                                   data_t imm);
    inst_t word;
    case (k)
      KAdd: word = {7'b0000000, rs2, rs1, 3'b000, rd, OpReg};
      KSub: word = {7'b0100000, rs2, rs1, 3'b000, rd, OpReg};
      KAnd: word = {7'b0000000, rs2, rs1, 3'b111, rd, OpReg};
      KOr: word = {7'b0000000, rs2, rs1, 3'b110, rd, OpReg};
      KXor: word = {7'b0000000, rs2, rs1, 3'b100, rd, OpReg};
      KSlt: word = {7'b0000000, rs2, rs1, 3'b010, rd, OpReg};
      KSll: word = {7'b0000000, rs2, rs1, 3'b001, rd, OpReg};
      KSrl: word = {7'b0000000, rs2, rs1, 3'b101, rd, OpReg};
      KAddi: word = {imm[11:0], rs1, 3'b000, rd, OpImm};
      KAndi: word = {imm[11:0], rs1, 3'b111, rd, OpImm};
      KOri: word = {imm[11:0], rs1, 3'b110, rd, OpImm};
      KXori: word = {imm[11:0], rs1, 3'b100, rd, OpImm};
      KSlti: word = {imm[11:0], rs1, 3'b010, rd, OpImm};
      KSlli: word = {7'b0000000, imm[4:0], rs1, 3'b001, rd, OpImm};
      KSrli: word = {7'b0000000, imm[4:0], rs1, 3'b101, rd, OpImm};
      KLui: word = {imm[31:12], rd, OpLui};
      KLw: word = {imm[11:0], rs1, 3'b010, rd, OpLoad};
      KSw: word = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OpStore};
      KBeq: word = {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], OpBranch};
      KBne: word = {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], OpBranch};
      KJal: word = {imm[20], imm[10:1], imm[11], imm[19:12], rd, OpJal};
      default: word = nop_inst;
    endcase
    return word;
  endfunction

  // RV32I result of the arithmetic and LUI kinds
  function automatic data_t expected_result(kind_t k, data_t a, data_t b);
    case (k)
      KSub: return a - b;
      KAnd, KAndi: return a & b;
      KOr, KOri: return a | b;
      KXor, KXori: return a ^ b;
      KSlt, KSlti: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      KSll, KSlli: return a << b[4:0];
      KSrl, KSrli: return a >> b[4:0];
      KLui: return b;
      default: return a + b;
    endcase
  endfunction

  task automatic build_program();
    kind_t k;
    data_t r;
    int span;
    for (int i = 0; i < 256; i++) begin
      kind[i] = KAddi;
      rd_f[i] = '0;
      rs1_f[i] = '0;
      rs2_f[i] = '0;
      imm_f[i] = '0;
    end
    for (int i = 0; i < n_random; i++) begin
      k = kind_t'($urandom_range(KJal, KAdd));
      r = $urandom();
      span = $urandom_range(8, 1);
      // Forward jumps never pass the first final store
      if (i + span > n_random) begin
        span = n_random - i;
      end
      kind[i] = k;
      rd_f[i] = reg_addr_t'($urandom_range(7, 1));
      rs1_f[i] = reg_addr_t'($urandom_range(7, 0));
      rs2_f[i] = reg_addr_t'($urandom_range(7, 0));
      imm_f[i] = {{20{r[11]}}, r[11:0]};
      case (k)
        KSlli, KSrli: imm_f[i] = {27'b0, r[4:0]};
        KLui: imm_f[i] = {r[31:12], 12'b0};
        KLw, KSw: begin
          rs1_f[i] = '0;
          imm_f[i] = {24'b0, r[5:0], 2'b00};
        end
        KBeq, KBne, KJal: imm_f[i] = data_t'(4 * span);
        default: ;
      endcase
    end
    // Dump x1..x7, then spin
    for (int j = 0; j < 7; j++) begin
      kind[n_random + j] = KSw;
      rs2_f[n_random + j] = reg_addr_t'(j + 1);
      imm_f[n_random + j] = data_t'(4 * (56 + j));
    end
    kind[loop_index] = KJal;
    for (int i = 0; i < 256; i++) begin
      prog[i] = encode(kind[i], rd_f[i], rs1_f[i], rs2_f[i], imm_f[i]);
    end
  endtask

  // Sequential execution, one instruction per step
  task automatic run_model();
    data_t regs [0:31];
    data_t mem [0:63];
    data_t a;
    data_t b;
    data_t addr;
    int pc;
    int next_pc;
    int steps;
    for (int n = 0; n < 32; n++) begin
      regs[n] = '0;
    end
    for (int w = 0; w < 64; w++) begin
      mem[w] = dmem[w];
    end
    pc = 0;
    steps = 0;
    while (pc != loop_index) begin
      if (steps == max_model_steps) begin
        stop_with_failure("Reference model never reached the final loop");
      end
      a = regs[rs1_f[pc]];
      b = (kind[pc] <= KSrl) ? regs[rs2_f[pc]] : imm_f[pc];
      addr = a + imm_f[pc];
      next_pc = pc + 1;
      case (kind[pc])
        KLw: regs[rd_f[pc]] = mem[addr[7:2]];
        KSw: begin
          exp_addr.push_back(addr);
          exp_data.push_back(regs[rs2_f[pc]]);
          mem[addr[7:2]] = regs[rs2_f[pc]];
        end
        KBeq: begin
          if (regs[rs1_f[pc]] == regs[rs2_f[pc]]) begin
            next_pc = pc + int'(imm_f[pc] >> 2);
          end
        end
        KBne: begin
          if (regs[rs1_f[pc]] != regs[rs2_f[pc]]) begin
            next_pc = pc + int'(imm_f[pc] >> 2);
          end
        end
        KJal: begin
          regs[rd_f[pc]] = data_t'(4 * pc + 4);
          next_pc = pc + int'(imm_f[pc] >> 2);
        end
        default: regs[rd_f[pc]] = expected_result(kind[pc], a, b);
      endcase
      regs[0] = '0;
      pc = next_pc;
      steps++;
    end
  endtask

  // Called on each falling edge; mem_busy set here governs the next rising edge
  task automatic serve_memory();
    if (busy_left > 0) begin
      mem_busy = 1'b1;
      busy_left--;
    end else if ($urandom_range(7, 0) == 0) begin
      mem_busy = 1'b1;
      busy_left = $urandom_range(2, 0);
    end else begin
      mem_busy = 1'b0;
    end
    inst = prog[inst_mem_addr[9:2]];
    // Read data only while a load asks for it
    rd_data = rd_en ? dmem[data_mem_addr[7:2]] : '0;
    if (wr_en && !mem_busy) begin
      if (seen_stores >= exp_addr.size()) begin
        stop_with_failure("A store appeared after the last expected store");
      end
      check($sformatf("store %0d address", seen_stores), exp_addr[seen_stores], data_mem_addr);
      check($sformatf("store %0d data", seen_stores), exp_data[seen_stores], wr_data);
      dmem[data_mem_addr[7:2]] = wr_data;
      seen_stores++;
    end
  endtask

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    inst = nop_inst;
    rd_data = '0;
    mem_busy = 1'b0;
    busy_left = 0;
    seen_stores = 0;
    verdict_printed = 1'b0;
    void'($urandom(60546));
    for (int w = 0; w < 64; w++) begin
      dmem[w] = (data_t'(w) * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
    end
    build_program();
    run_model();

    repeat (4) @(negedge clock);
    reset = 1'b0;
    check("reset inst_mem_addr", 32'd0, inst_mem_addr);
    check("reset rd_en", 32'd0, {31'b0, rd_en});
    check("reset wr_en", 32'd0, {31'b0, wr_en});

    cycles = 0;
    while (seen_stores < exp_addr.size()) begin
      if (cycles == max_cycles) begin
        stop_with_failure("Timed out waiting for the expected stores");
      end
      serve_memory();
      @(negedge clock);
      cycles++;
    end

    // Core spins on the final JAL, no more stores allowed
    for (int n = 0; n < drain_cycles; n++) begin
      serve_memory();
      @(negedge clock);
    end

    $display("Testbench passed");
    verdict_printed = 1'b1;
    $finish;
  end

  final begin
    if (!verdict_printed) begin
      $display("Testbench failed");
    end
  end

endmodule
